//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_control_unit
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' files.f) test/tb_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): files.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
logic/cu_pkg.sv
logic/instr_fetch.sv
logic/op_sequencer.sv
logic/control_word.sv
logic/control_unit.sv
+incdir+test
test/tb_control_unit.sv

//--- logic/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input wire clk,
	input wire rst,
	input wire start,
	input wire z,
	input wire mem_rd_done,
	input wire mem_wr_done,
	input wire cu_pkg::word_t m_ins_data,
	output cu_pkg::word_t m_ins_add,
	output logic rd_m_ins,
	output logic rd_mi,
	output logic wr_mo,
	output cu_pkg::load_vect_t load_vect,
	output cu_pkg::clear_vect_t clear_vect,
	output cu_pkg::sel_t amux,
	output cu_pkg::sel_t bmux,
	output cu_pkg::sel_t alu_op,
	output logic pass_ac,
	output logic end_flag
);

	// fetch controls from the table
	logic clr_fetch;
	logic ld_ir;
	logic inc_pc;
	logic ld_pc;
	cu_pkg::word_t opcode;
	cu_pkg::state_t state_next;

	instr_fetch u_fetch (
		.clk(clk),
		.rst(rst),
		.clr_fetch(clr_fetch),
		.ld_ir(ld_ir),
		.inc_pc(inc_pc),
		.ld_pc(ld_pc),
		.m_ins_data(m_ins_data),
		.opcode(opcode),
		.m_ins_add(m_ins_add)
	);

	op_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.z(z),
		.mem_rd_done(mem_rd_done),
		.mem_wr_done(mem_wr_done),
		.opcode(opcode),
		.state_next(state_next)
	);

	control_word u_word (
		.clk(clk),
		.rst(rst),
		.state_next(state_next),
		.clr_fetch(clr_fetch),
		.ld_ir(ld_ir),
		.inc_pc(inc_pc),
		.ld_pc(ld_pc),
		.rd_m_ins(rd_m_ins),
		.rd_mi(rd_mi),
		.wr_mo(wr_mo),
		.pass_ac(pass_ac),
		.end_flag(end_flag),
		.load_vect(load_vect),
		.clear_vect(clear_vect),
		.amux(amux),
		.bmux(bmux),
		.alu_op(alu_op)
	);

endmodule

`default_nettype wire

//--- logic/control_word.sv
`timescale 1ns/1ps
`default_nettype none

module control_word (
	input wire clk,
	input wire rst,
	input wire cu_pkg::state_t state_next,
	output logic clr_fetch,
	output logic ld_ir,
	output logic inc_pc,
	output logic ld_pc,
	output logic rd_m_ins,
	output logic rd_mi,
	output logic wr_mo,
	output logic pass_ac,
	output logic end_flag,
	output cu_pkg::load_vect_t load_vect,
	output cu_pkg::clear_vect_t clear_vect,
	output cu_pkg::sel_t amux,
	output cu_pkg::sel_t bmux,
	output cu_pkg::sel_t alu_op
);

	// one flat word of 9 strobes, load, clear and three selects
	localparam int word_w = 9 + 9 + 6 + 9;

	logic [word_w-1:0] word_d;
	logic [word_w-1:0] word_q;

	// table entry for the state about to be entered
	always_comb begin
		logic [8:0] s;
		cu_pkg::load_vect_t ld;
		cu_pkg::clear_vect_t clr;
		cu_pkg::sel_t am;
		cu_pkg::sel_t bm;
		cu_pkg::sel_t op;
		s = '0;
		ld = '0;
		clr = '0;
		am = '0;
		bm = '0;
		op = '0;
		// s from msb is clr_fetch ld_ir inc_pc ld_pc rd_m_ins rd_mi wr_mo pass_ac end_flag
		case (state_next)
			cu_pkg::idle: s[8] = 1'b1;
			cu_pkg::fetch1: s[4] = 1'b1;
			cu_pkg::fetch2: s = 9'b0_1101_0000;
			cu_pkg::ldac_wait: begin
				s[3] = 1'b1;
				ld[cu_pkg::ld_mi_ac] = 1'b1;
			end
			cu_pkg::mvacrh: ld[cu_pkg::ld_ac_rh] = 1'b1;
			cu_pkg::strsrk_wait: s[2] = 1'b1;
			cu_pkg::clac: clr[cu_pkg::clr_ac] = 1'b1;
			cu_pkg::clrs: clr[cu_pkg::clr_rs] = 1'b1;
			cu_pkg::addrxac1: ld[cu_pkg::ld_ac_rs] = 1'b1;
			cu_pkg::addrxac2: begin
				s[1] = 1'b1;
				ld[cu_pkg::ld_ac_rx] = 1'b1;
				ld[cu_pkg::ld_alu_ac] = 1'b1;
				bm = 3'd3;
			end
			cu_pkg::divrs: begin
				s[1] = 1'b1;
				ld[cu_pkg::ld_ac_rs] = 1'b1;
				ld[cu_pkg::ld_alu_ac] = 1'b1;
				op = 3'd1;
			end
			cu_pkg::subrhrj: begin
				ld[cu_pkg::ld_alu_ac] = 1'b1;
				am = 3'd2;
				op = 3'd2;
			end
			cu_pkg::inri: begin
				s[1] = 1'b1;
				ld[cu_pkg::ld_ac_ri] = 1'b1;
				ld[cu_pkg::ld_alu_ac] = 1'b1;
				am = 3'd1;
				op = 3'd3;
			end
			cu_pkg::decrx: begin
				s[1] = 1'b1;
				ld[cu_pkg::ld_ac_rx] = 1'b1;
				ld[cu_pkg::ld_alu_ac] = 1'b1;
				bm = 3'd3;
				op = 3'd5;
			end
			cu_pkg::jump1: s = 9'b0_0011_0000;
			cu_pkg::jmpz_skip: s[6] = 1'b1;
			cu_pkg::end_op: s[0] = 1'b1;
			default: s = '0;
		endcase
		word_d = {s, ld, clr, am, bm, op};
	end

	always_ff @(posedge clk) begin
		if (!rst)
			// idle entry
			word_q <= {9'b1_0000_0000, {(word_w - 9){1'b0}}};
		else
			word_q <= word_d;
	end

	assign {clr_fetch, ld_ir, inc_pc, ld_pc, rd_m_ins, rd_mi, wr_mo, pass_ac, end_flag,
		load_vect, clear_vect, amux, bmux, alu_op} = word_q;

	a_clear_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(clear_vect));

	a_rd_wr: assert property (@(posedge clk) disable iff (!rst) !(rd_mi && wr_mo));

endmodule

`default_nettype wire

//--- logic/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// instructions, opcodes and addresses
	typedef logic [7:0] word_t;
	typedef logic [8:0] load_vect_t;
	typedef logic [5:0] clear_vect_t;
	// amux, bmux and alu_op
	typedef logic [2:0] sel_t;

	// load vector bit positions
	localparam int ld_mi_ac = 0;
	localparam int ld_alu_ac = 1;
	localparam int ld_ac_rh = 2;
	localparam int ld_ac_rw = 3;
	localparam int ld_ac_rs = 4;
	localparam int ld_ac_rx = 5;
	localparam int ld_ac_ri = 6;
	localparam int ld_ac_rj = 7;
	localparam int ld_ac_rk = 8;

	// clear vector bit positions
	localparam int clr_ac = 0;
	localparam int clr_rs = 1;
	localparam int clr_rx = 2;
	localparam int clr_ri = 3;
	localparam int clr_rj = 4;
	localparam int clr_rk = 5;

	// opcode values
	localparam word_t op_ldac = 8'd3;
	localparam word_t op_mvacrh = 8'd5;
	localparam word_t op_strsrk = 8'd7;
	localparam word_t op_clac = 8'd9;
	localparam word_t op_clrs = 8'd11;
	localparam word_t op_addrxac = 8'd15;
	localparam word_t op_divrs = 8'd19;
	localparam word_t op_subrhrj = 8'd20;
	localparam word_t op_inri = 8'd22;
	localparam word_t op_decrx = 8'd26;
	localparam word_t op_jump = 8'd31;
	localparam word_t op_jmpz = 8'd33;
	localparam word_t op_end = 8'd37;

	typedef enum logic [4:0] {
		idle, fetch1, fetch2, decode,
		ldac_wait, mvacrh, strsrk_wait, clac, clrs,
		addrxac1, addrxac2, divrs, subrhrj, inri, decrx,
		jump1, jmpz_test, jmpz_skip, end_op
	} state_t;

endpackage

`default_nettype wire

//--- logic/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
	input wire clk,
	input wire rst,
	input wire clr_fetch,
	input wire ld_ir,
	input wire inc_pc,
	input wire ld_pc,
	input wire cu_pkg::word_t m_ins_data,
	output cu_pkg::word_t opcode,
	output cu_pkg::word_t m_ins_add
);

	cu_pkg::word_t ir;
	cu_pkg::word_t pc;

	always_ff @(posedge clk) begin
		if (!rst || clr_fetch) begin
			ir <= '0;
			pc <= '0;
		end else begin
			if (ld_ir)
				ir <= m_ins_data;
			// jump target comes straight from instruction memory
			if (ld_pc)
				pc <= m_ins_data;
			else if (inc_pc)
				pc <= pc + 8'd1;
		end
	end

	assign opcode = ir;
	assign m_ins_add = pc;

	// table never loads and steps the pc together
	a_pc_ctrl: assert property (@(posedge clk) disable iff (!rst) !(inc_pc && ld_pc));

endmodule

`default_nettype wire

//--- logic/op_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module op_sequencer (
	input wire clk,
	input wire rst,
	input wire start,
	input wire z,
	input wire mem_rd_done,
	input wire mem_wr_done,
	input wire cu_pkg::word_t opcode,
	output cu_pkg::state_t state_next
);

	cu_pkg::state_t state;
	logic rd_flag;
	logic wr_flag;

	always_ff @(posedge clk) begin
		if (!rst)
			state <= cu_pkg::idle;
		else
			state <= state_next;
	end

	// sticky done flags where a pulse beats the fetch2 clear
	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_flag <= 1'b0;
			wr_flag <= 1'b0;
		end else begin
			if (mem_rd_done)
				rd_flag <= 1'b1;
			else if (state == cu_pkg::fetch2)
				rd_flag <= 1'b0;
			if (mem_wr_done)
				wr_flag <= 1'b1;
			else if (state == cu_pkg::fetch2)
				wr_flag <= 1'b0;
		end
	end

	always_comb begin
		state_next = cu_pkg::idle;
		case (state)
			cu_pkg::idle:
				state_next = start ? cu_pkg::fetch1 : cu_pkg::idle;
			cu_pkg::fetch1:
				state_next = cu_pkg::fetch2;
			cu_pkg::fetch2:
				state_next = cu_pkg::decode;
			cu_pkg::decode: begin
				case (opcode)
					cu_pkg::op_ldac: state_next = cu_pkg::ldac_wait;
					cu_pkg::op_mvacrh: state_next = cu_pkg::mvacrh;
					cu_pkg::op_strsrk: state_next = cu_pkg::strsrk_wait;
					cu_pkg::op_clac: state_next = cu_pkg::clac;
					cu_pkg::op_clrs: state_next = cu_pkg::clrs;
					cu_pkg::op_addrxac: state_next = cu_pkg::addrxac1;
					cu_pkg::op_divrs: state_next = cu_pkg::divrs;
					cu_pkg::op_subrhrj: state_next = cu_pkg::subrhrj;
					cu_pkg::op_inri: state_next = cu_pkg::inri;
					cu_pkg::op_decrx: state_next = cu_pkg::decrx;
					cu_pkg::op_jump: state_next = cu_pkg::jump1;
					cu_pkg::op_jmpz: state_next = cu_pkg::jmpz_test;
					cu_pkg::op_end: state_next = cu_pkg::end_op;
					// unknown opcode
					default: state_next = cu_pkg::idle;
				endcase
			end
			cu_pkg::ldac_wait:
				state_next = rd_flag ? cu_pkg::fetch1 : cu_pkg::ldac_wait;
			cu_pkg::strsrk_wait:
				state_next = wr_flag ? cu_pkg::fetch1 : cu_pkg::strsrk_wait;
			cu_pkg::addrxac1:
				state_next = cu_pkg::addrxac2;
			// z is only looked at here
			cu_pkg::jmpz_test:
				state_next = z ? cu_pkg::jump1 : cu_pkg::jmpz_skip;
			cu_pkg::end_op:
				state_next = cu_pkg::idle;
			cu_pkg::mvacrh, cu_pkg::clac, cu_pkg::clrs, cu_pkg::addrxac2,
			cu_pkg::divrs, cu_pkg::subrhrj, cu_pkg::inri, cu_pkg::decrx,
			cu_pkg::jump1, cu_pkg::jmpz_skip:
				state_next = cu_pkg::fetch1;
			default:
				state_next = cu_pkg::idle;
		endcase
	end

	a_state_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(state));

	a_decode_once: assert property (@(posedge clk) disable iff (!rst)
		(state == cu_pkg::decode) |=> (state != cu_pkg::decode));

endmodule

`default_nettype wire

//--- test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// model state stepped once per rising edge
cu_pkg::state_t m_state;
cu_pkg::word_t m_pc;
cu_pkg::word_t m_ir;
logic m_rd_flag;
logic m_wr_flag;
logic [31:0] rng_state = 32'h812b_16f0;
// next program to copy into imem at a drive point
cu_pkg::word_t prog [256];
logic prog_ready;

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// {rd_m_ins, rd_mi, wr_mo, pass_ac, end_flag, load_vect, clear_vect, amux, bmux, alu_op}
function automatic logic [28:0] expected_word(input cu_pkg::state_t s);
	logic rd_ins;
	logic rd;
	logic wr;
	logic pass;
	logic fin;
	cu_pkg::load_vect_t ld;
	cu_pkg::clear_vect_t clr;
	cu_pkg::sel_t am;
	cu_pkg::sel_t bm;
	cu_pkg::sel_t op;
	{rd_ins, rd, wr, pass, fin} = 5'b0;
	ld = '0;
	clr = '0;
	am = '0;
	bm = '0;
	op = '0;
	case (s)
		cu_pkg::fetch1, cu_pkg::fetch2, cu_pkg::jump1: rd_ins = 1'b1;
		cu_pkg::ldac_wait: begin
			rd = 1'b1;
			ld[cu_pkg::ld_mi_ac] = 1'b1;
		end
		cu_pkg::mvacrh: ld[cu_pkg::ld_ac_rh] = 1'b1;
		cu_pkg::strsrk_wait: wr = 1'b1;
		cu_pkg::clac: clr[cu_pkg::clr_ac] = 1'b1;
		cu_pkg::clrs: clr[cu_pkg::clr_rs] = 1'b1;
		cu_pkg::addrxac1: ld[cu_pkg::ld_ac_rs] = 1'b1;
		cu_pkg::addrxac2: begin
			ld[cu_pkg::ld_ac_rx] = 1'b1;
			ld[cu_pkg::ld_alu_ac] = 1'b1;
			bm = 3'd3;
			pass = 1'b1;
		end
		cu_pkg::divrs: begin
			ld[cu_pkg::ld_ac_rs] = 1'b1;
			ld[cu_pkg::ld_alu_ac] = 1'b1;
			op = 3'd1;
			pass = 1'b1;
		end
		cu_pkg::subrhrj: begin
			ld[cu_pkg::ld_alu_ac] = 1'b1;
			am = 3'd2;
			op = 3'd2;
		end
		cu_pkg::inri: begin
			ld[cu_pkg::ld_ac_ri] = 1'b1;
			ld[cu_pkg::ld_alu_ac] = 1'b1;
			am = 3'd1;
			op = 3'd3;
			pass = 1'b1;
		end
		cu_pkg::decrx: begin
			ld[cu_pkg::ld_ac_rx] = 1'b1;
			ld[cu_pkg::ld_alu_ac] = 1'b1;
			bm = 3'd3;
			op = 3'd5;
			pass = 1'b1;
		end
		cu_pkg::end_op: fin = 1'b1;
		default: ;
	endcase
	return {rd_ins, rd, wr, pass, fin, ld, clr, am, bm, op};
endfunction

function automatic cu_pkg::state_t decode_target(input cu_pkg::word_t op);
	cu_pkg::state_t t;
	case (op)
		cu_pkg::op_ldac: t = cu_pkg::ldac_wait;
		cu_pkg::op_mvacrh: t = cu_pkg::mvacrh;
		cu_pkg::op_strsrk: t = cu_pkg::strsrk_wait;
		cu_pkg::op_clac: t = cu_pkg::clac;
		cu_pkg::op_clrs: t = cu_pkg::clrs;
		cu_pkg::op_addrxac: t = cu_pkg::addrxac1;
		cu_pkg::op_divrs: t = cu_pkg::divrs;
		cu_pkg::op_subrhrj: t = cu_pkg::subrhrj;
		cu_pkg::op_inri: t = cu_pkg::inri;
		cu_pkg::op_decrx: t = cu_pkg::decrx;
		cu_pkg::op_jump: t = cu_pkg::jump1;
		cu_pkg::op_jmpz: t = cu_pkg::jmpz_test;
		cu_pkg::op_end: t = cu_pkg::end_op;
		default: t = cu_pkg::idle;
	endcase
	return t;
endfunction

// inputs are the values seen at this rising edge
task automatic model_step(input logic rst_v, input logic start_v, input logic z_v,
	input logic rd_v, input logic wr_v);
	cu_pkg::state_t nxt;
	case (m_state)
		cu_pkg::idle: nxt = start_v ? cu_pkg::fetch1 : cu_pkg::idle;
		cu_pkg::fetch1: nxt = cu_pkg::fetch2;
		cu_pkg::fetch2: nxt = cu_pkg::decode;
		cu_pkg::decode: nxt = decode_target(m_ir);
		cu_pkg::ldac_wait: nxt = m_rd_flag ? cu_pkg::fetch1 : cu_pkg::ldac_wait;
		cu_pkg::strsrk_wait: nxt = m_wr_flag ? cu_pkg::fetch1 : cu_pkg::strsrk_wait;
		cu_pkg::addrxac1: nxt = cu_pkg::addrxac2;
		cu_pkg::jmpz_test: nxt = z_v ? cu_pkg::jump1 : cu_pkg::jmpz_skip;
		cu_pkg::end_op: nxt = cu_pkg::idle;
		// single-cycle operations
		default: nxt = cu_pkg::fetch1;
	endcase
	case (m_state)
		cu_pkg::idle: begin
			m_pc = 8'd0;
			m_ir = 8'd0;
		end
		cu_pkg::fetch2: begin
			m_ir = imem[m_pc];
			m_pc = m_pc + 8'd1;
		end
		cu_pkg::jump1: m_pc = imem[m_pc];
		cu_pkg::jmpz_skip: m_pc = m_pc + 8'd1;
		default: ;
	endcase
	if (rd_v)
		m_rd_flag = 1'b1;
	else if (m_state == cu_pkg::fetch2)
		m_rd_flag = 1'b0;
	if (wr_v)
		m_wr_flag = 1'b1;
	else if (m_state == cu_pkg::fetch2)
		m_wr_flag = 1'b0;
	m_state = nxt;
	if (!rst_v) begin
		m_state = cu_pkg::idle;
		m_pc = 8'd0;
		m_ir = 8'd0;
		m_rd_flag = 1'b0;
		m_wr_flag = 1'b0;
	end
endtask

// random kept opcodes with forward jumps and a last byte of op_end or an unknown code
task automatic build_program(input logic with_end);
	cu_pkg::word_t kept [12];
	cu_pkg::word_t ops [16];
	int addr [16];
	int n;
	int a;
	int i;
	int pick;
	kept = '{cu_pkg::op_ldac, cu_pkg::op_mvacrh, cu_pkg::op_strsrk, cu_pkg::op_clac,
		cu_pkg::op_clrs, cu_pkg::op_addrxac, cu_pkg::op_divrs, cu_pkg::op_subrhrj,
		cu_pkg::op_inri, cu_pkg::op_decrx, cu_pkg::op_jump, cu_pkg::op_jmpz};
	n = 4 + int'(next_random() % 13);
	for (i = 0; i < n - 1; i++)
		ops[i] = kept[int'(next_random() % 12)];
	if (with_end)
		ops[n - 1] = cu_pkg::op_end;
	else
		ops[n - 1] = cu_pkg::word_t'(40 + int'(next_random() % 150));
	a = 0;
	for (i = 0; i < n; i++) begin
		addr[i] = a;
		a += (ops[i] == cu_pkg::op_jump || ops[i] == cu_pkg::op_jmpz) ? 2 : 1;
	end
	for (a = 0; a < 256; a++)
		prog[a] = cu_pkg::word_t'(a) ^ 8'h5a;
	for (i = 0; i < n; i++) begin
		prog[addr[i]] = ops[i];
		if (ops[i] == cu_pkg::op_jump || ops[i] == cu_pkg::op_jmpz) begin
			pick = i + 1 + int'(next_random() % (n - 1 - i));
			prog[addr[i] + 1] = cu_pkg::word_t'(addr[pick]);
		end
	end
	prog_ready = 1'b1;
endtask

`endif

//--- test/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;

	localparam int half_period = 10;
	localparam int drive_delay = 2;
	localparam int reset_cycles = 10;
	localparam int num_programs = 24;
	localparam int run_limit = 2000;

	logic clk;
	logic rst;
	logic start;
	logic z;
	logic mem_rd_done;
	logic mem_wr_done;
	cu_pkg::word_t m_ins_data;
	cu_pkg::word_t m_ins_add;
	logic rd_m_ins;
	logic rd_mi;
	logic wr_mo;
	cu_pkg::load_vect_t load_vect;
	cu_pkg::clear_vect_t clear_vect;
	cu_pkg::sel_t amux;
	cu_pkg::sel_t bmux;
	cu_pkg::sel_t alu_op;
	logic pass_ac;
	logic end_flag;

	// instruction memory read without a clock
	cu_pkg::word_t imem [256];

	string test_name;
	int out_errors;
	int addr_errors;
	int other_errors;
	logic timed_out;

	`include "tb_model.svh"

	assign m_ins_data = imem[m_ins_add];

	control_unit u_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.z(z),
		.mem_rd_done(mem_rd_done),
		.mem_wr_done(mem_wr_done),
		.m_ins_data(m_ins_data),
		.m_ins_add(m_ins_add),
		.rd_m_ins(rd_m_ins),
		.rd_mi(rd_mi),
		.wr_mo(wr_mo),
		.load_vect(load_vect),
		.clear_vect(clear_vect),
		.amux(amux),
		.bmux(bmux),
		.alu_op(alu_op),
		.pass_ac(pass_ac),
		.end_flag(end_flag)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	task automatic check_outputs();
		logic [28:0] exp;
		logic [28:0] act;
		exp = expected_word(m_state);
		act = {rd_m_ins, rd_mi, wr_mo, pass_ac, end_flag, load_vect, clear_vect,
			amux, bmux, alu_op};
		assert (act === exp) else begin
			out_errors++;
			$display("error: %s in %s outputs expected %h actual %h",
				test_name, m_state.name(), exp, act);
		end
		assert (m_ins_add === m_pc) else begin
			addr_errors++;
			$display("error: %s in %s m_ins_add expected %h actual %h",
				test_name, m_state.name(), m_pc, m_ins_add);
		end
	endtask

	task automatic drive_random();
		logic [31:0] r;
		r = next_random();
		z = r[0];
		// done pulses never last two cycles
		mem_rd_done = !mem_rd_done && (r[9:8] == 2'b00);
		mem_wr_done = !mem_wr_done && (r[17:16] == 2'b00);
	endtask

	task automatic step_cycle(input logic rst_v, input logic start_v);
		@(posedge clk);
		model_step(rst, start, z, mem_rd_done, mem_wr_done);
		#drive_delay;
		rst = rst_v;
		start = start_v;
		drive_random();
		if (prog_ready) begin
			imem = prog;
			prog_ready = 1'b0;
		end
		@(negedge clk);
		check_outputs();
	endtask

	task automatic run_program(input logic with_end);
		int cycles;
		int ends;
		logic done;
		cycles = 0;
		ends = 0;
		done = 1'b0;
		step_cycle(1'b1, 1'b1);
		while (!done && cycles < run_limit) begin
			step_cycle(1'b1, 1'b0);
			cycles++;
			if (end_flag === 1'b1)
				ends++;
			if (with_end)
				done = (end_flag === 1'b1);
			else
				done = (m_state == cu_pkg::idle);
		end
		if (!done) begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout: %s did not finish within %0d cycles", test_name, run_limit);
		end else begin
			if (with_end) begin
				step_cycle(1'b1, 1'b0);
				assert (end_flag === 1'b0) else begin
					out_errors++;
					$display("error: %s end_flag after end expected 0 actual %b",
						test_name, end_flag);
				end
			end else begin
				assert (ends == 0) else begin
					other_errors++;
					$display("%s: end_flag went high after an unknown opcode", test_name);
				end
			end
			repeat (3) step_cycle(1'b1, 1'b0);
		end
	endtask

	initial begin
		int a;
		int prog_no;
		logic with_end;
		rst = 1'b0;
		start = 1'b0;
		z = 1'b0;
		mem_rd_done = 1'b0;
		mem_wr_done = 1'b0;
		prog_ready = 1'b0;
		out_errors = 0;
		addr_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		for (a = 0; a < 256; a++)
			imem[a] = cu_pkg::word_t'(a) ^ 8'h5a;

		test_name = "reset";
		repeat (reset_cycles) step_cycle(1'b0, 1'b0);
		test_name = "idle";
		repeat (4) step_cycle(1'b1, 1'b0);

		for (prog_no = 0; prog_no < num_programs && !timed_out; prog_no++) begin
			test_name = $sformatf("program %0d", prog_no);
			// every fourth program stops on an unknown opcode
			with_end = (prog_no % 4) != 3;
			build_program(with_end);
			step_cycle(1'b1, 1'b0);
			run_program(with_end);
		end

		$display("errors: outputs %0d, address %0d, other %0d",
			out_errors, addr_errors, other_errors);
		if (out_errors + addr_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
